//--- design/board_gen.sv
/*
 * solution board generator
 * derives two seed values from the random indices and builds
 * a valid 4x4 board from them and their mirrors
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module board_gen (
   input  logic                  clka,
   input  logic                  arst_n,
   input  logic                  restart,
   input  logic                  set_board,
   input  sudoku_pkg::cell_idx_t ridx_a,
   input  sudoku_pkg::cell_idx_t ridx_b,
   output sudoku_pkg::board_t    solution,
   output sudoku_pkg::cell_idx_t ridx_a_q,
   output sudoku_pkg::cell_idx_t ridx_b_q
);

   import sudoku_pkg::*;

   cell_t  a, b, a_m, b_m;
   board_t board_d;
   logic   cells_ok;

   // seed values
   always_comb begin
      if (!ridx_a[1]) begin
         a = ridx_a[0] ? cell_t'(4) : cell_t'(1);
         b = ridx_b[0] ? cell_t'(3) : cell_t'(2);
      end else begin
         a = ridx_a[0] ? cell_t'(3) : cell_t'(2);
         b = ridx_b[0] ? cell_t'(4) : cell_t'(1);
      end
   end

   assign a_m = mirror(a);
   assign b_m = mirror(b);

   // rows listed from cell 3 down to cell 0 of each row
   assign board_d = {{a,   b_m, b,   a_m},
                     {b,   a_m, a,   b_m},
                     {b_m, a,   a_m, b  },
                     {a_m, b,   b_m, a  }};

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         solution <= '0;
         ridx_a_q <= '0;
         ridx_b_q <= '0;
      end else if (restart) begin
         solution <= '0;
         ridx_a_q <= '0;
         ridx_b_q <= '0;
      end else if (set_board) begin
         solution <= board_d;
         ridx_a_q <= ridx_a;
         ridx_b_q <= ridx_b;
      end
   end

   // ------------------------------
   always_comb begin
      cells_ok = 1'b1;
      for (int i = 0; i < `SUDOKU_CELLS; i++) begin
         if (solution[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] == '0 ||
             solution[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] > `SUDOKU_MAX_VAL)
            cells_ok = 1'b0;
      end
   end

   a_solution_range: assert property (@(posedge clka) disable iff (!arst_n)
      set_board && !restart |=> cells_ok);

endmodule

//--- design/cell_entry.sv
/*
 * player board
 * takes hint values from the solution and guarded player
 * entries into cells that are not fixed
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module cell_entry (
   input  logic                   clka,
   input  logic                   arst_n,
   input  logic                   restart,
   input  sudoku_pkg::board_t     solution,
   input  sudoku_pkg::cell_mask_t fixed_mask,
   input  sudoku_pkg::cell_mask_t hint_mask,
   input  logic                   hint_wr,
   input  logic                   enter,
   input  sudoku_pkg::cell_idx_t  cell_sel,
   input  sudoku_pkg::entry_t     value_inp,
   output sudoku_pkg::board_t     player_board
);

   import sudoku_pkg::*;

   cell_t entry_val;

   // raw 0..3 maps to 1..4
   assign entry_val = cell_t'(value_inp) + cell_t'(1);

   // ------------------------------
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         player_board <= '0;
      end else if (restart) begin
         player_board <= '0;
      end else begin
         for (int i = 0; i < `SUDOKU_CELLS; i++) begin
            // hint write has priority
            if (hint_wr && hint_mask[i]) begin
               player_board[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] <=
                  solution[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W];
            end else if (enter && cell_sel == i && !fixed_mask[i]) begin
               player_board[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] <= entry_val;
            end
         end
      end
   end

   // entry aimed at a hint cell is dropped
   a_fixed_hold: assert property (@(posedge clka) disable iff (!arst_n)
      enter && fixed_mask[cell_sel] && !hint_wr && !restart |=> $stable(player_board));

endmodule

//--- design/hint_place.sv
/*
 * hint placement
 * picks the fixed hint cells for the chosen difficulty and
 * accumulates them into the fixed-cell mask
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module hint_place (
   input  logic                   clka,
   input  logic                   arst_n,
   input  logic                   restart,
   input  logic                   load_hints,
   input  sudoku_pkg::level_t     difficulty,
   input  sudoku_pkg::cell_idx_t  ridx_a_q,
   input  sudoku_pkg::cell_idx_t  ridx_b_q,
   output sudoku_pkg::cell_mask_t fixed_mask,
   output sudoku_pkg::cell_mask_t hint_mask,
   output logic                   hint_wr
);

   import sudoku_pkg::*;

   logic [`SUDOKU_SIDE-1:0] row_1, row_2;
   cell_mask_t              new_mask;

   // single cell of a row
   function automatic logic [`SUDOKU_SIDE-1:0] one_cell(input logic [1:0] sel);
      return `SUDOKU_SIDE'(1) << sel;
   endfunction

   // outer or inner pair of a row
   function automatic logic [`SUDOKU_SIDE-1:0] cell_pair(input logic [1:0] sel);
      return (sel == 2'd0 || sel == 2'd3) ? 4'b1001 : 4'b0110;
   endfunction

   // ------------------------------
   // per-level group selection
   always_comb begin
      row_1 = one_cell(ridx_a_q[3:2]);
      row_2 = one_cell(ridx_b_q[1:0]);
      if (difficulty == `LEVEL_EASY)
         row_1 = cell_pair(ridx_a_q[3:2]);
      if (difficulty == `LEVEL_EASY || difficulty == `LEVEL_MEDIUM)
         row_2 = cell_pair(ridx_b_q[1:0]);

      new_mask = {one_cell(ridx_b_q[3:2]), row_2, row_1, one_cell(ridx_a_q[1:0])};
      if (difficulty == `LEVEL_NONE)
         new_mask = '0;
   end

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         fixed_mask <= '0;
         hint_mask  <= '0;
         hint_wr    <= 1'b0;
      end else if (restart) begin
         fixed_mask <= '0;
         hint_mask  <= '0;
         hint_wr    <= 1'b0;
      end else begin
         hint_wr <= load_hints;
         if (load_hints) begin
            fixed_mask <= fixed_mask | new_mask;
            hint_mask  <= new_mask;
         end
      end
   end

   // 6, 5 or 4 new cells per load
   a_hint_count: assert property (@(posedge clka) disable iff (!arst_n)
      load_hints && !restart && difficulty != `LEVEL_NONE |=>
         $countones(hint_mask) == (($past(difficulty) == `LEVEL_EASY)   ? 6 :
                                   ($past(difficulty) == `LEVEL_MEDIUM) ? 5 : 4));

endmodule

//--- design/solve_check.sv
/*
 * solution check
 * compares the player board against the solution on a check strobe
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module solve_check (
   input  logic               clka,
   input  logic               arst_n,
   input  logic               restart,
   input  logic               check,
   input  sudoku_pkg::board_t player_board,
   input  sudoku_pkg::board_t solution,
   output logic               solved
);

   import sudoku_pkg::*;

   cell_mask_t cell_match;

   // cell-wise compare
   always_comb begin
      for (int i = 0; i < `SUDOKU_CELLS; i++) begin
         cell_match[i] = player_board[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] ==
                         solution[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W];
      end
   end

   // held until next check
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n)
         solved <= 1'b0;
      else if (restart)
         solved <= 1'b0;
      else if (check)
         solved <= &cell_match;
   end

endmodule

//--- design/sudoku_defs.svh
/*
 * 4x4 sudoku datapath constants
 * board geometry, cell value range and difficulty codes
 */

`ifndef SUDOKU_DEFS_SVH
`define SUDOKU_DEFS_SVH

// board geometry
`define SUDOKU_SIDE     4
`define SUDOKU_CELLS    (`SUDOKU_SIDE * `SUDOKU_SIDE)
`define SUDOKU_IDX_W    4

// cell values 1..4, 0 is empty
`define SUDOKU_CELL_W   3
`define SUDOKU_MAX_VAL  4
`define SUDOKU_ENTRY_W  2

// difficulty codes
`define SUDOKU_LEVEL_W  2
`define LEVEL_NONE      2'd0
`define LEVEL_EASY      2'd1
`define LEVEL_MEDIUM    2'd2
`define LEVEL_HARD      2'd3

`endif

//--- design/sudoku_dp.sv
/*
 * 4x4 sudoku datapath
 * board generation, hint placement, player entry and solve check
 * in a four-stage chain on one clock
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module sudoku_dp (
   input  logic                   clka,
   input  logic                   arst_n,
   input  logic                   restart,
   input  logic                   set_board,
   input  logic                   load_hints,
   input  logic                   enter,
   input  logic                   check,
   input  sudoku_pkg::level_t     difficulty,
   input  sudoku_pkg::cell_idx_t  ridx_a,
   input  sudoku_pkg::cell_idx_t  ridx_b,
   input  sudoku_pkg::cell_idx_t  cell_sel,
   input  sudoku_pkg::entry_t     value_inp,
   output sudoku_pkg::board_t     user_board,
   output sudoku_pkg::cell_mask_t fill_flag,
   output logic                   solved
);

   import sudoku_pkg::*;

   board_t     solution;
   cell_idx_t  ridx_a_q, ridx_b_q;
   cell_mask_t hint_mask;
   logic       hint_wr;

   // ------------------------------
   board_gen u_board_gen (
      .clka      (clka),
      .arst_n    (arst_n),
      .restart   (restart),
      .set_board (set_board),
      .ridx_a    (ridx_a),
      .ridx_b    (ridx_b),
      .solution  (solution),
      .ridx_a_q  (ridx_a_q),
      .ridx_b_q  (ridx_b_q)
   );

   // fixed mask goes straight out as fill_flag
   hint_place u_hint_place (
      .clka       (clka),
      .arst_n     (arst_n),
      .restart    (restart),
      .load_hints (load_hints),
      .difficulty (difficulty),
      .ridx_a_q   (ridx_a_q),
      .ridx_b_q   (ridx_b_q),
      .fixed_mask (fill_flag),
      .hint_mask  (hint_mask),
      .hint_wr    (hint_wr)
   );

   cell_entry u_cell_entry (
      .clka         (clka),
      .arst_n       (arst_n),
      .restart      (restart),
      .solution     (solution),
      .fixed_mask   (fill_flag),
      .hint_mask    (hint_mask),
      .hint_wr      (hint_wr),
      .enter        (enter),
      .cell_sel     (cell_sel),
      .value_inp    (value_inp),
      .player_board (user_board)
   );

   solve_check u_solve_check (
      .clka         (clka),
      .arst_n       (arst_n),
      .restart      (restart),
      .check        (check),
      .player_board (user_board),
      .solution     (solution),
      .solved       (solved)
   );

   // one command per cycle
   a_cmd_onehot: assert property (@(posedge clka) disable iff (!arst_n)
      $onehot0({set_board, load_hints, enter, check}));

endmodule

//--- design/sudoku_pkg.sv
/*
 * 4x4 sudoku datapath types
 * cell, index, board and mask vectors plus the value mirror
 */

`include "sudoku_defs.svh"

package sudoku_pkg;

   // one cell value, 0 means empty
   typedef logic [`SUDOKU_CELL_W-1:0] cell_t;

   // row * 4 + column
   typedef logic [`SUDOKU_IDX_W-1:0] cell_idx_t;

   // cell i lives in slice i
   typedef logic [`SUDOKU_CELLS*`SUDOKU_CELL_W-1:0] board_t;

   typedef logic [`SUDOKU_CELLS-1:0] cell_mask_t;
   typedef logic [`SUDOKU_LEVEL_W-1:0] level_t;

   // raw player value, 0..3 stands for 1..4
   typedef logic [`SUDOKU_ENTRY_W-1:0] entry_t;

   // pairs 1 with 4 and 2 with 3
   function automatic cell_t mirror(input cell_t v);
      return cell_t'(`SUDOKU_MAX_VAL + 1) - v;
   endfunction

endpackage

//--- testbench/tb_sudoku_dp.sv
/*
 * 4x4 sudoku datapath testbench
 * drives board, hint, entry, check and restart commands and
 * compares the DUT outputs with a reference model
 */

`timescale 1ns/1ps

`include "sudoku_defs.svh"

module tb_sudoku_dp;

   import sudoku_pkg::*;

   // restart, set_board, load_hints per pass, then setup plus entries per board
   localparam int CMD_CYCLES     = 4;
   localparam int TEST_CMDS      = 64*3 + 4*6 + 4*5 + 4*18 + 15;
   localparam int TIMEOUT_CYCLES = 16 + CMD_CYCLES*TEST_CMDS + 500;

   logic       clka, arst_n, restart, set_board, load_hints, enter, check, solved;
   level_t     difficulty;
   cell_idx_t  ridx_a, ridx_b, cell_sel, saved_a, saved_b;
   entry_t     value_inp;
   board_t     user_board, exp_sol, exp_board;
   cell_mask_t fill_flag, exp_fix;
   logic       exp_solved;
   int         err_count = 0;
   int         test_errs = 0;
   int         cycles = 0;
   int         cmp_seq = 0;
   int         cmp_done = 0;

   sudoku_dp DUT (
      .clka(clka), .arst_n(arst_n), .restart(restart), .set_board(set_board),
      .load_hints(load_hints), .enter(enter), .check(check), .difficulty(difficulty),
      .ridx_a(ridx_a), .ridx_b(ridx_b), .cell_sel(cell_sel), .value_inp(value_inp),
      .user_board(user_board), .fill_flag(fill_flag), .solved(solved)
   );

   always #2 clka = ~clka;

   // ------------------------------
   // reference model
   function automatic cell_t solution_cell(input cell_idx_t ra, input cell_idx_t rb,
                                           input int idx);
      cell_t a, b;
      if (!ra[1]) begin
         a = ra[0] ? 3'd4 : 3'd1;
         b = rb[0] ? 3'd3 : 3'd2;
      end else begin
         a = ra[0] ? 3'd3 : 3'd2;
         b = rb[0] ? 3'd4 : 3'd1;
      end
      case (idx)
         0, 6, 9, 15:  return a;
         3, 5, 10, 12: return mirror(a);
         2, 4, 11, 13: return b;
         default:      return mirror(b);
      endcase
   endfunction

   function automatic board_t solution_board(input cell_idx_t ra, input cell_idx_t rb);
      board_t brd;
      for (int i = 0; i < `SUDOKU_CELLS; i++)
         brd[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] = solution_cell(ra, rb, i);
      return brd;
   endfunction

   function automatic cell_mask_t hint_cells(input cell_idx_t ra, input cell_idx_t rb,
                                             input level_t lvl);
      cell_mask_t m;
      m = '0;
      if (lvl == `LEVEL_NONE)
         return m;
      m[ra[1:0]] = 1'b1;
      m[12 + rb[3:2]] = 1'b1;
      if (lvl != `LEVEL_EASY)
         m[4 + ra[3:2]] = 1'b1;
      else if (ra[3:2] == 2'd0 || ra[3:2] == 2'd3)
         m = m | 16'h0090;
      else
         m = m | 16'h0060;
      if (lvl == `LEVEL_HARD)
         m[8 + rb[1:0]] = 1'b1;
      else if (rb[1:0] == 2'd0 || rb[1:0] == 2'd3)
         m = m | 16'h0900;
      else
         m = m | 16'h0600;
      return m;
   endfunction

   // ------------------------------
   task automatic check_value(input string name, input board_t expected, input board_t actual);
      if (actual !== expected) begin
         $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
         err_count++;
      end
   endtask

   // outputs settle at the rising edge, so compare on the falling one
   always @(negedge clka) begin
      if (cmp_seq != cmp_done) begin
         check_value("user_board", exp_board, user_board);
         check_value("fill_flag", board_t'(exp_fix), board_t'(fill_flag));
         check_value("solved", board_t'(exp_solved), board_t'(solved));
         cmp_done = cmp_seq;
      end
   end

   always @(posedge clka) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: test sequence still running after %0d cycles", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   // strobe edge, release, then compare 3 cycles on
   task automatic run_command;
      @(posedge clka);
      #1;
      restart = 1'b0;
      set_board = 1'b0;
      load_hints = 1'b0;
      enter = 1'b0;
      check = 1'b0;
      repeat (2) @(posedge clka);
      #1;
      cmp_seq++;
      @(posedge clka);
      #1;
   endtask

   task automatic restart_game;
      restart = 1'b1;
      exp_sol = '0;
      exp_board = '0;
      exp_fix = '0;
      exp_solved = 1'b0;
      saved_a = '0;
      saved_b = '0;
      run_command();
   endtask

   task automatic place_board(input cell_idx_t ra, input cell_idx_t rb);
      set_board = 1'b1;
      ridx_a = ra;
      ridx_b = rb;
      saved_a = ra;
      saved_b = rb;
      exp_sol = solution_board(ra, rb);
      run_command();
   endtask

   task automatic place_hints(input level_t lvl);
      cell_mask_t new_cells;
      load_hints = 1'b1;
      difficulty = lvl;
      new_cells = hint_cells(saved_a, saved_b, lvl);
      exp_fix = exp_fix | new_cells;
      for (int i = 0; i < `SUDOKU_CELLS; i++) begin
         if (new_cells[i])
            exp_board[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] =
               exp_sol[i*`SUDOKU_CELL_W +: `SUDOKU_CELL_W];
      end
      run_command();
   endtask

   task automatic enter_value(input cell_idx_t idx, input entry_t val);
      enter = 1'b1;
      cell_sel = idx;
      value_inp = val;
      if (!exp_fix[idx])
         exp_board[idx*`SUDOKU_CELL_W +: `SUDOKU_CELL_W] = cell_t'(val) + 3'd1;
      run_command();
   endtask

   task automatic request_check;
      check = 1'b1;
      exp_solved = (exp_board == exp_sol);
      run_command();
   endtask

   // enter the model solution into every free cell
   task automatic fill_free_cells;
      cell_t sol_val;
      for (int c = 0; c < `SUDOKU_CELLS; c++) begin
         sol_val = exp_sol[c*`SUDOKU_CELL_W +: `SUDOKU_CELL_W];
         if (!exp_fix[c])
            enter_value(cell_idx_t'(c), entry_t'(sol_val - 3'd1));
      end
   endtask

   task automatic setup_game(input level_t lvl);
      restart_game();
      place_board(cell_idx_t'($urandom), cell_idx_t'($urandom));
      place_hints(lvl);
   endtask

   task automatic pick_cell(input logic want_fixed, output cell_idx_t idx);
      idx = cell_idx_t'($urandom);
      while (exp_fix[idx] != want_fixed)
         idx = cell_idx_t'($urandom);
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, err_count - test_errs);
      test_errs = err_count;
   endtask

   // ------------------------------
   initial begin
      int unsigned rnd;
      cell_idx_t   idx, ra, rb;
      clka = 1'b0;
      arst_n = 1'b0;
      restart = 1'b0;
      set_board = 1'b0;
      load_hints = 1'b0;
      enter = 1'b0;
      check = 1'b0;
      difficulty = `LEVEL_NONE;
      ridx_a = '0;
      ridx_b = '0;
      cell_sel = '0;
      value_inp = '0;
      rnd = $urandom(32'h02e6_8615);
      repeat (16) @(posedge clka);
      #1;
      arst_n = 1'b1;

      // low index bits and level sweep, upper bits random
      for (int i = 0; i < 64; i++) begin
         ra = cell_idx_t'($urandom);
         rb = cell_idx_t'($urandom);
         ra[1:0] = i[1:0];
         rb[0] = i[2];
         restart_game();
         place_board(ra, rb);
         place_hints(level_t'(i >> 3));
      end
      report_test(1, "hint placement");

      for (int b = 0; b < 4; b++) begin
         setup_game(level_t'(1 + $urandom % 3));
         repeat (3) begin
            pick_cell(1'b0, idx);
            enter_value(idx, entry_t'($urandom));
         end
      end
      report_test(2, "free cell entry");

      for (int b = 0; b < 4; b++) begin
         setup_game(level_t'(1 + $urandom % 3));
         repeat (2) begin
            pick_cell(1'b1, idx);
            enter_value(idx, entry_t'($urandom));
         end
      end
      report_test(3, "fixed cell entry");

      for (int b = 0; b < 4; b++) begin
         setup_game(level_t'(1 + $urandom % 3));
         fill_free_cells();
         request_check();
         check_value("solved", board_t'(1), board_t'(solved));
         // next value up, 4 wraps to 1
         pick_cell(1'b0, idx);
         enter_value(idx, entry_t'(exp_sol[idx*`SUDOKU_CELL_W +: `SUDOKU_CELL_W]));
         request_check();
         check_value("solved", board_t'(0), board_t'(solved));
      end
      report_test(4, "solve check");

      // solved board first, so restart has something to clear
      setup_game(`LEVEL_EASY);
      fill_free_cells();
      request_check();
      check_value("solved", board_t'(1), board_t'(solved));
      restart_game();
      check_value("user_board", '0, user_board);
      check_value("fill_flag", '0, board_t'(fill_flag));
      check_value("solved", '0, board_t'(solved));
      report_test(5, "restart");

      $display("done: 5 tests, %0d errors, %0d cycles", err_count, cycles);
      if (err_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+design
design/sudoku_pkg.sv
design/board_gen.sv
design/hint_place.sv
design/cell_entry.sv
design/solve_check.sv
design/sudoku_dp.sv
testbench/tb_sudoku_dp.sv
